/* rtl/bch_pkg.sv */
package bch_pkg;

	// ************************************************************
	// code constants, (15,7) bch over gf(16).
	// ************************************************************

	localparam int m = 4; // bits per field element.
	localparam int code_n = 15; // codeword length.
	localparam int code_k = 7; // message length.

	localparam logic [8:0] gen_poly = 9'b1_1101_0001; // x^8+x^7+x^6+x^4+1.
	localparam logic [4:0] prim_poly = 5'b1_0011; // x^4+x+1.

	// error count codes.
	localparam logic [1:0] err_none = 2'd0;
	localparam logic [1:0] err_one = 2'd1;
	localparam logic [1:0] err_two = 2'd2;
	localparam logic [1:0] err_many = 2'd3;

	// ************************************************************
	// gf(16) arithmetic.
	// ************************************************************

	// shift and add, reduced by prim_poly each step.
	function automatic logic [m-1:0] gf_mul(input logic [m-1:0] a, input logic [m-1:0] b);
		logic [m-1:0] acc;
		logic [m-1:0] sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < m; i++) begin
			if (b[i])
				acc = acc ^ sh;
			sh = {sh[m-2:0], 1'b0} ^ (sh[m-1] ? prim_poly[m-1:0] : '0); // times alpha.
		end
		return acc;
	endfunction

	function automatic logic [m-1:0] gf_sq(input logic [m-1:0] a);
		return gf_mul(a, a);
	endfunction

	function automatic logic [m-1:0] gf_pow3(input logic [m-1:0] a);
		return gf_mul(gf_sq(a), a);
	endfunction

	// alpha^e for e in 0..14; only ever called with constants.
	function automatic logic [m-1:0] gf_alpha_pow(input logic [3:0] e);
		logic [m-1:0] r;
		r = 4'b0001;
		for (int i = 0; i < code_n; i++) begin
			if (i < int'(e))
				r = gf_mul(r, 4'b0010); // alpha is x.
		end
		return r;
	endfunction

endpackage

/* rtl/bch_encoder.sv */
module bch_encoder import bch_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic enc_start, // pulse, ignored mid burst.
	input logic [code_k-1:0] msg,
	output logic code_bit,
	output logic code_valid // high for 15 cycles.
);

	logic [code_k-1:0] msg_sr; // message, msb goes out first.
	logic [7:0] par; // parity lfsr.
	logic [3:0] cnt; // bit index in burst.
	logic go;
	logic fb;
	logic in_msg;

	assign go = enc_start & ~code_valid;
	assign in_msg = cnt < 4'(code_k);
	assign fb = msg_sr[code_k-1] ^ par[7]; // division feedback.

	// message bits first, then remainder.
	assign code_bit = in_msg ? msg_sr[code_k-1] : par[7];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			code_valid <= 1'b0;
			cnt <= '0;
		end else if (go) begin
			code_valid <= 1'b1;
			cnt <= '0;
		end else if (code_valid) begin
			if (cnt == 4'(code_n - 1)) begin
				code_valid <= 1'b0; // burst done.
				cnt <= '0;
			end else
				cnt <= cnt + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (go) begin
			msg_sr <= msg;
			par <= '0;
		end else if (code_valid) begin
			if (in_msg) begin
				msg_sr <= {msg_sr[code_k-2:0], 1'b0};
				par <= {par[6:0], 1'b0} ^ (fb ? gen_poly[7:0] : 8'h00); // mod g(x).
			end else
				par <= {par[6:0], 1'b0}; // shift parity out.
		end
	end

endmodule

/* rtl/bch_syndrome.sv */
module bch_syndrome import bch_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic rx_bit,
	input logic rx_valid,
	output logic rx_ready, // low while a word is decoded.
	output logic syn_start, // pulse, word complete.
	output logic [2*m-1:0] syndromes, // {s3, s1}.
	output logic [code_n-1:0] word, // received word, bit p is x^p.
	input logic done // result presented.
);

	logic [3:0] cnt; // bits accepted so far.
	logic [m-1:0] s1_acc;
	logic [m-1:0] s3_acc;
	logic [m-1:0] s1_next;
	logic [m-1:0] s3_next;
	logic take;
	logic last_bit;

	assign take = rx_valid & rx_ready;
	assign last_bit = cnt == 4'(code_n - 1);

	// horner steps, highest degree arrives first.
	assign s1_next = gf_mul(s1_acc, gf_alpha_pow(4'd1)) ^ m'(rx_bit); // r(alpha).
	assign s3_next = gf_mul(s3_acc, gf_pow3(gf_alpha_pow(4'd1))) ^ m'(rx_bit); // r(alpha^3).

	// ************************************************************
	// accumulators and flow control.
	// ************************************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			s1_acc <= '0;
			s3_acc <= '0;
			syn_start <= 1'b0;
			rx_ready <= 1'b1;
		end else begin
			syn_start <= 1'b0;
			if (take) begin
				if (last_bit) begin
					cnt <= '0;
					s1_acc <= '0; // ready for the next word.
					s3_acc <= '0;
					syn_start <= 1'b1;
					rx_ready <= 1'b0; // hold off until done.
				end else begin
					cnt <= cnt + 4'd1;
					s1_acc <= s1_next;
					s3_acc <= s3_next;
				end
			end else if (done)
				rx_ready <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			word <= {word[code_n-2:0], rx_bit}; // still while rx_ready is low.
		if (take && last_bit)
			syndromes <= {s3_next, s1_next};
	end

endmodule

/* rtl/bch_chien.sv */
module bch_chien import bch_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic start, // load sigma.
	input logic [3*m-1:0] sigma, // {s3, s1^2, s1}.
	input logic err_feedback, // error found at this step.
	output logic [3*m-1:0] chien, // scaled terms.
	output logic ready,
	output logic first,
	output logic last,
	output logic valid
);

	logic [m-1:0] t1; // s1 * alpha^-p.
	logic [m-1:0] t2; // s1^2 * alpha^-2p.
	logic [m-1:0] t3; // s3 * alpha^-3p.
	logic [m-1:0] t1_fb;
	logic [m-1:0] t2_fb;
	logic [m-1:0] t3_fb;
	logic arm; // hold cycle after start.
	logic run;
	logic [3:0] pos; // bit position under test.

	// fold a found error out of the terms.
	// the squared term follows s1 so the cube stays consistent.
	assign t1_fb = t1 ^ m'(err_feedback);
	assign t2_fb = t2 ^ m'(err_feedback);
	assign t3_fb = t3 ^ m'(err_feedback);

	assign chien = {t3, t2, t1};
	assign valid = run;
	assign first = run & (pos == 4'd0);
	assign last = run & (pos == 4'(code_n - 1));
	assign ready = ~(start | arm | run);

	// ************************************************************
	// step control.
	// ************************************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arm <= 1'b0;
			run <= 1'b0;
			pos <= '0;
		end else begin
			arm <= start;
			if (arm) begin
				run <= 1'b1; // position 0 next.
				pos <= '0;
			end else if (run) begin
				if (last)
					run <= 1'b0;
				pos <= pos + 4'd1;
			end
		end
	end

	// terms are left unscaled through the hold cycle.
	always_ff @(posedge clk) begin
		if (start) begin
			t1 <= sigma[0*m +: m];
			t2 <= sigma[1*m +: m];
			t3 <= sigma[2*m +: m];
		end else if (run) begin
			t1 <= gf_mul(t1_fb, gf_alpha_pow(4'd14)); // alpha^-1.
			t2 <= gf_mul(t2_fb, gf_alpha_pow(4'd13)); // alpha^-2.
			t3 <= gf_mul(t3_fb, gf_alpha_pow(4'd12)); // alpha^-3.
		end
	end

endmodule

/* rtl/bch_error_dec.sv */
module bch_error_dec import bch_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic start, // syndromes valid.
	input logic [2*m-1:0] syndromes, // {s3, s1}.
	output logic [1:0] err_count, // count of the received word.
	output logic ready,
	output logic first,
	output logic last,
	output logic valid,
	output logic err // flip bit at this position.
);

	logic [3*m-1:0] sigma;
	logic [3*m-1:0] chien;
	logic [m-1:0] s1;
	logic [m-1:0] s3;
	logic first_cycle; // classify unflipped terms.
	logic flip;
	logic [m-1:0] ch1_flipped;
	logic [m-1:0] ch2_flipped;
	logic [m-1:0] ch3_flipped;
	logic [m-1:0] cube;
	logic [1:0] errors;
	logic [1:0] errors_last; // count before this step.

	assign s1 = syndromes[0 +: m];
	assign s3 = syndromes[m +: m];

	// s2 = s1^2 for a binary code.
	assign sigma = {s3, gf_sq(s1), s1};

	bch_chien u_chien (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.sigma(sigma),
		.err_feedback(err),
		.chien(chien),
		.ready(ready),
		.first(first),
		.last(last),
		.valid(valid)
	);

	// ************************************************************
	// error count of the word with the tested bit flipped.
	// ************************************************************

	// scaled terms of bit p are all 1, so flip is xor 1.
	assign flip = ~first_cycle;
	assign ch1_flipped = chien[0*m +: m] ^ m'(flip);
	assign ch2_flipped = chien[1*m +: m] ^ m'(flip);
	assign ch3_flipped = chien[2*m +: m] ^ m'(flip);

	assign cube = gf_mul(ch1_flipped, ch2_flipped); // s1 * s1^2.

	// dec: sigma(x) = 1 + s1 x + (s1^2 + s3/s1) x^2.
	always_comb begin
		if (|ch1_flipped)
			errors = (cube == ch3_flipped) ? err_one : err_two;
		else
			errors = (|ch3_flipped) ? err_many : err_none;
	end

	// a flip that lowers the count is an error.
	assign err = valid & (errors < errors_last);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			first_cycle <= 1'b0;
			errors_last <= err_none;
			err_count <= err_none;
		end else begin
			first_cycle <= start;
			if (start)
				errors_last <= err_none;
			else if (first_cycle || err)
				errors_last <= errors; // new baseline.
			if (first_cycle)
				err_count <= errors;
		end
	end

endmodule

/* rtl/bch_corrector.sv */
module bch_corrector import bch_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic [code_n-1:0] word,
	input logic load, // word valid.
	input logic err, // flip current position.
	input logic valid,
	input logic last,
	input logic [1:0] err_count,
	output logic dec_valid, // one cycle.
	output logic [code_k-1:0] dec_data,
	output logic [1:0] dec_err_count,
	output logic dec_uncorrectable,
	output logic done
);

	logic [code_n-1:0] word_q; // word under correction.
	logic [code_n-1:0] word_next;
	logic [code_k-1:0] raw_msg; // message as received.
	logic [3:0] pos; // tracks the chien position.
	logic [1:0] flips; // marked so far.
	logic [1:0] flips_next;
	logic hit;
	logic unc;

	assign hit = valid & err;
	assign word_next = word_q ^ (hit ? (code_n'(1) << pos) : '0);
	assign flips_next = flips + 2'(hit);

	// flips must agree with the classified count.
	assign unc = (err_count == err_many) || (flips_next != err_count);

	assign done = dec_valid; // releases rx_ready.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pos <= '0;
			flips <= '0;
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= valid & last;
			if (load) begin
				pos <= '0;
				flips <= '0;
			end else if (valid) begin
				pos <= pos + 4'd1;
				flips <= flips_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			word_q <= word;
			raw_msg <= word[code_n-1 -: code_k];
		end else if (valid)
			word_q <= word_next;
		if (valid && last) begin
			dec_data <= unc ? raw_msg : word_next[code_n-1 -: code_k]; // message is x^14..x^8.
			dec_err_count <= err_count;
			dec_uncorrectable <= unc;
		end
	end

endmodule

/* rtl/bch_codec_top.sv */
module bch_codec_top import bch_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic enc_start,
	input logic [code_k-1:0] msg,
	output logic code_bit,
	output logic code_valid,
	input logic rx_bit,
	input logic rx_valid,
	output logic rx_ready,
	output logic dec_valid,
	output logic [code_k-1:0] dec_data,
	output logic [1:0] dec_err_count,
	output logic dec_uncorrectable
);

	logic syn_start;
	logic [2*m-1:0] syndromes;
	logic [code_n-1:0] word;
	logic [1:0] err_count;
	logic err;
	logic chien_valid;
	logic chien_last;
	logic done;

	bch_encoder u_encoder (
		.clk(clk),
		.arst_n(arst_n),
		.enc_start(enc_start),
		.msg(msg),
		.code_bit(code_bit),
		.code_valid(code_valid)
	);

	// ************************************************************
	// decode chain, syndromes then chien then correction.
	// ************************************************************

	bch_syndrome u_syndrome (
		.clk(clk),
		.arst_n(arst_n),
		.rx_bit(rx_bit),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.syn_start(syn_start),
		.syndromes(syndromes),
		.word(word),
		.done(done)
	);

	// ready and first are not needed downstream.
	bch_error_dec u_error_dec (
		.clk(clk),
		.arst_n(arst_n),
		.start(syn_start),
		.syndromes(syndromes),
		.err_count(err_count),
		.ready(),
		.first(),
		.last(chien_last),
		.valid(chien_valid),
		.err(err)
	);

	bch_corrector u_corrector (
		.clk(clk),
		.arst_n(arst_n),
		.word(word),
		.load(syn_start),
		.err(err),
		.valid(chien_valid),
		.last(chien_last),
		.err_count(err_count),
		.dec_valid(dec_valid),
		.dec_data(dec_data),
		.dec_err_count(dec_err_count),
		.dec_uncorrectable(dec_uncorrectable),
		.done(done)
	);

endmodule

/* verification/tb_bch.sv */
module tb_bch;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_tests = 40;
	localparam int cycles_per_test = 60; // gap tests are the longest.
	localparam int timeout_cycles = n_tests * cycles_per_test;
	localparam logic [8:0] g_poly = 9'b1_1101_0001; // x^8+x^7+x^6+x^4+1.

	logic clk;
	logic arst_n;
	logic enc_start;
	logic [6:0] msg;
	logic code_bit;
	logic code_valid;
	logic rx_bit;
	logic rx_valid;
	logic rx_ready;
	logic dec_valid;
	logic [6:0] dec_data;
	logic [1:0] dec_err_count;
	logic dec_uncorrectable;

	integer seed;
	int error_count;
	int tests_run;
	int tests_failed;
	int errs_at_start;
	int cycles;
	string test_name;
	logic [14:0] codebook [0:127]; // codeword of every message.
	logic [14:0] exp_code;
	logic [6:0] exp_data;
	logic [1:0] exp_cnt_lo; // wider range when undecodable.
	logic [1:0] exp_cnt_hi;
	logic exp_unc;
	logic [3:0] enc_idx; // degree of the next code bit.
	logic [4:0] hi_len; // code_valid run so far.
	logic [3:0] acc_cnt; // bits accepted in this word.
	logic pending; // word inside the decoder.
	logic [4:0] lat; // cycles since the 15th bit.
	logic accept_last;

	bch_codec_top u_dut (
		.clk(clk),
		.arst_n(arst_n),
		.enc_start(enc_start),
		.msg(msg),
		.code_bit(code_bit),
		.code_valid(code_valid),
		.rx_bit(rx_bit),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.dec_valid(dec_valid),
		.dec_data(dec_data),
		.dec_err_count(dec_err_count),
		.dec_uncorrectable(dec_uncorrectable)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period.
	end

	// ************************************************************
	// trackers for the timing checks.
	// ************************************************************

	assign accept_last = rx_valid & rx_ready & (acc_cnt == 4'd14);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			enc_idx <= 4'd14;
			hi_len <= '0;
			acc_cnt <= '0;
			pending <= 1'b0;
			lat <= '0;
		end else begin
			hi_len <= code_valid ? hi_len + 5'd1 : 5'd0;
			if (code_valid)
				enc_idx <= (enc_idx == 4'd0) ? 4'd14 : enc_idx - 4'd1; // msb first.
			if (rx_valid && rx_ready)
				acc_cnt <= (acc_cnt == 4'd14) ? 4'd0 : acc_cnt + 4'd1;
			if (accept_last) begin
				pending <= 1'b1;
				lat <= 5'd1;
			end else if (dec_valid)
				pending <= 1'b0; // result is out.
			else if (pending)
				lat <= lat + 5'd1;
		end
	end

	task automatic report(input string text);
		error_count++;
		$display("%s", text);
	endtask

	a_code_len: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(code_valid) |-> hi_len == 5'd15)
		else report($sformatf("FAILED %s: expected code_valid length 15, actual %0d",
			test_name, $sampled(hi_len)));
	a_code_long: assert property (@(posedge clk) disable iff (!arst_n)
		code_valid |-> hi_len < 5'd15)
		else report($sformatf("code_valid stayed high past 15 cycles in %s", test_name));
	a_code_rise: assert property (@(posedge clk) disable iff (!arst_n)
		enc_start && !code_valid |=> code_valid)
		else report($sformatf("code_valid did not rise after enc_start in %s", test_name));
	a_code_bit: assert property (@(posedge clk) disable iff (!arst_n)
		code_valid |-> code_bit == exp_code[enc_idx])
		else report($sformatf("FAILED %s: expected bit %b at x^%0d, actual %b", test_name,
			exp_code[$sampled(enc_idx)], $sampled(enc_idx), $sampled(code_bit)));
	a_latency: assert property (@(posedge clk) disable iff (!arst_n)
		dec_valid |-> pending && lat == 5'd18)
		else report($sformatf("FAILED %s: expected latency 18, actual %0d",
			test_name, $sampled(lat)));
	a_latency_max: assert property (@(posedge clk) disable iff (!arst_n)
		pending |-> lat <= 5'd18)
		else report($sformatf("no dec_valid within 18 cycles in %s", test_name));
	a_ready_low: assert property (@(posedge clk) disable iff (!arst_n)
		pending |-> !rx_ready)
		else report($sformatf("rx_ready high while a word is decoded in %s", test_name));
	a_ready_back: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(pending) |-> rx_ready)
		else report($sformatf("rx_ready did not return after dec_valid in %s", test_name));
	a_fields: assert property (@(posedge clk) disable iff (!arst_n)
		dec_valid |-> dec_data == exp_data && dec_err_count >= exp_cnt_lo
			&& dec_err_count <= exp_cnt_hi && dec_uncorrectable == exp_unc)
		else report($sformatf(
			"FAILED %s: expected data %h count %0d..%0d unc %b, actual data %h count %0d unc %b",
			test_name, exp_data, exp_cnt_lo, exp_cnt_hi, exp_unc,
			dec_data, dec_err_count, dec_uncorrectable));

	// ************************************************************
	// reference model and stimulus.
	// ************************************************************

	// long division of m(x)*x^8 by g(x).
	// the remainder ends up in [14:7].
	function automatic logic [14:0] model_codeword(input logic [6:0] m_in);
		logic [14:0] d;
		d = {m_in, 8'h00};
		repeat (7) begin
			if (d[14])
				d = d ^ {g_poly, 6'b0};
			d = d << 1;
		end
		return {m_in, d[14:7]};
	endfunction

	function automatic logic [14:0] error_mask(input int k);
		logic [14:0] mask;
		logic [3:0] p;
		mask = '0;
		while ($countones(mask) < k) begin
			p = 4'($unsigned($random(seed)) % 15); // distinct positions.
			mask[p] = 1'b1;
		end
		return mask;
	endfunction

	// nearest codeword by search over the whole code.
	task automatic expect_decode(input logic [14:0] r);
		int best;
		int best_i;
		int d;
		best = 16;
		best_i = 0;
		for (int i = 0; i < 128; i++) begin
			d = $countones(codebook[7'(i)] ^ r);
			if (d < best) begin
				best = d;
				best_i = i;
			end
		end
		exp_unc = best > 2;
		exp_data = exp_unc ? r[14:8] : 7'(best_i); // raw message if undecodable.
		exp_cnt_lo = exp_unc ? 2'd2 : 2'(best);
		exp_cnt_hi = exp_unc ? 2'd3 : 2'(best);
	endtask

	task automatic open_test(input string name);
		test_name = name;
		errs_at_start = error_count;
	endtask

	task automatic close_test();
		tests_run++;
		if (error_count != errs_at_start)
			tests_failed++;
		$display("%-14s %s", test_name, (error_count == errs_at_start) ? "pass" : "fail");
	endtask

	task automatic send_word(input logic [14:0] w, input int max_gap);
		logic [14:0] sr;
		int gap;
		sr = w;
		@(negedge clk);
		while (!rx_ready)
			@(negedge clk);
		for (int i = 0; i < 15; i++) begin
			gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
			repeat (gap) begin
				@(posedge clk);
				rx_valid <= 1'b0;
			end
			@(posedge clk);
			rx_bit <= sr[14]; // x^14 first.
			rx_valid <= 1'b1;
			sr = sr << 1;
		end
		@(posedge clk);
		rx_valid <= 1'b0;
	endtask

	// one more edge so the checks on dec_valid have run.
	task automatic wait_result();
		@(negedge clk);
		while (!dec_valid)
			@(negedge clk);
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic decode_case(input string name, input logic [14:0] w, input int max_gap);
		open_test(name);
		expect_decode(w);
		send_word(w, max_gap);
		wait_result();
		close_test();
	endtask

	task automatic encode_case(input string name, input logic [6:0] m_in);
		open_test(name);
		exp_code = model_codeword(m_in);
		@(posedge clk);
		msg <= m_in;
		enc_start <= 1'b1;
		@(posedge clk);
		enc_start <= 1'b0;
		repeat (4)
			@(posedge clk);
		msg <= ~m_in; // a start inside the burst is ignored.
		enc_start <= 1'b1;
		@(posedge clk);
		enc_start <= 1'b0;
		@(negedge clk);
		while (code_valid)
			@(negedge clk);
		@(posedge clk);
		@(negedge clk);
		close_test();
	endtask

	task automatic reset_mid_word();
		open_test("reset_mid");
		repeat (7) begin
			@(posedge clk);
			rx_bit <= 1'($random(seed));
			rx_valid <= 1'b1;
		end
		@(posedge clk);
		rx_valid <= 1'b0;
		arst_n <= 1'b0; // half a word in.
		@(negedge clk);
		a_reset: assert (rx_ready && !dec_valid && !code_valid)
			else report($sformatf("rx_ready low, dec_valid or code_valid high during reset in %s",
				test_name));
		repeat (2)
			@(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		close_test();
	endtask

	initial begin
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, a code burst or a result never ended", cycles);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		logic [14:0] w;
		seed = 91266;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		test_name = "reset";
		arst_n = 1'b0;
		enc_start = 1'b0;
		msg = '0;
		rx_bit = 1'b0;
		rx_valid = 1'b0;
		exp_code = '0;
		exp_data = '0;
		exp_cnt_lo = '0;
		exp_cnt_hi = '0;
		exp_unc = 1'b0;
		for (int i = 0; i < 128; i++)
			codebook[7'(i)] = model_codeword(7'(i));
		repeat (8)
			@(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		for (int i = 0; i < 8; i++)
			encode_case($sformatf("encode_%0d", i), 7'($random(seed)));
		for (int i = 0; i < 24; i++) begin
			w = codebook[7'($random(seed))] ^ error_mask(i / 6); // 0 to 3 errors.
			decode_case($sformatf("errors%0d_%0d", i / 6, i % 6), w, 0);
		end
		for (int i = 0; i < 6; i++) begin
			w = codebook[7'($random(seed))] ^ error_mask(i % 3);
			decode_case($sformatf("gaps_%0d", i), w, 2);
		end
		reset_mid_word();
		decode_case("after_reset", codebook[7'($random(seed))], 0);
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* tb.f */
rtl/bch_pkg.sv
rtl/bch_encoder.sv
rtl/bch_syndrome.sv
rtl/bch_chien.sv
rtl/bch_error_dec.sv
rtl/bch_corrector.sv
rtl/bch_codec_top.sv
verification/tb_bch.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bch codec testbench with verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_bch -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_bch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
	echo "simulation reported failures"
	exit 1
fi

echo "simulation passed"
exit 0
